/* dv/vector_lane_chk.sv */
// Handshake checker for the vector lane that is bound to the top level
`timescale 1ns/1ps
`default_nettype none

module vector_lane_chk (
  input logic            clk_i,
  input logic            rst_ni,
  input logic            cmd_valid_i,
  input logic            cmd_ready_i,
  input logic            alu_done_i,
  input logic            ldu_valid_i,
  input logic            ldu_ready_i,
  input lane_pkg::elem_t stu_data_i,
  input logic            stu_data_valid_i,
  input logic            stu_data_ready_i
);

  // Failed assertions so far
  int unsigned fail_count = 0;

  // Store data frozen while the consumer stalls
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    stu_data_valid_i && !stu_data_ready_i |=> $stable(stu_data_i))
    else begin
      $error("store data changed while stalled");
      fail_count++;
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    alu_done_i |=> !alu_done_i)
    else begin
      $error("ALU done longer than one cycle");
      fail_count++;
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    ldu_ready_i |-> ldu_valid_i)
    else begin
      $error("load grant without a load request");
      fail_count++;
    end

  // Busy from acceptance until the done pulse
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_valid_i && cmd_ready_i |=> !cmd_ready_i)
    else begin
      $error("command port still ready after acceptance");
      fail_count++;
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(cmd_ready_i) |-> alu_done_i)
    else begin
      $error("command port ready again without ALU done");
      fail_count++;
    end

endmodule

bind vector_lane vector_lane_chk vector_lane_chk_inst (
  .clk_i            (clk_i           ),
  .rst_ni           (rst_ni          ),
  .cmd_valid_i      (cmd_valid_i     ),
  .cmd_ready_i      (cmd_ready_o     ),
  .alu_done_i       (alu_done_o      ),
  .ldu_valid_i      (ldu_valid_i     ),
  .ldu_ready_i      (ldu_ready_o     ),
  .stu_data_i       (stu_data_o      ),
  .stu_data_valid_i (stu_data_valid_o),
  .stu_data_ready_i (stu_data_ready_i)
);

`default_nettype wire

/* dv/vector_lane_tb.sv */
// Testbench for the vector lane with random loads, ALU ops and store read-back
`timescale 1ns/1ps
`default_nettype none
`include "lane_params.svh"

module vector_lane_tb;

  localparam int unsigned nr_words = `LANE_NR_VREGS * `LANE_ELEMS_PER_VREG;
  localparam int unsigned timeout_cycles = 200;

  logic               clk, rst_n;
  lane_pkg::alu_cmd_t cmd;
  logic               cmd_valid, cmd_ready, alu_done;
  lane_pkg::vrf_req_t ldu_req;
  logic               ldu_valid, ldu_ready;
  lane_pkg::vaddr_t   stu_addr;
  logic               stu_req_valid, stu_req_ready;
  lane_pkg::elem_t    stu_data;
  logic               stu_data_valid, stu_data_ready;

  // Expected VRF contents
  lane_pkg::elem_t model [nr_words];
  logic [31:0]     rng_state;
  int unsigned     errors, checks, tests, failed_tests, errors_at_start;

  vector_lane vector_lane_inst (
    .clk_i            (clk           ),
    .rst_ni           (rst_n         ),
    .cmd_i            (cmd           ),
    .cmd_valid_i      (cmd_valid     ),
    .cmd_ready_o      (cmd_ready     ),
    .alu_done_o       (alu_done      ),
    .ldu_req_i        (ldu_req       ),
    .ldu_valid_i      (ldu_valid     ),
    .ldu_ready_o      (ldu_ready     ),
    .stu_addr_i       (stu_addr      ),
    .stu_req_valid_i  (stu_req_valid ),
    .stu_req_ready_o  (stu_req_ready ),
    .stu_data_o       (stu_data      ),
    .stu_data_valid_o (stu_data_valid),
    .stu_data_ready_i (stu_data_ready)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic lane_pkg::elem_t next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic lane_pkg::vaddr_t word_addr(input lane_pkg::vreg_t v, input int e);
    return {v, lane_pkg::elem_idx_t'(e)};
  endfunction

  // Element rule of each op with SUB wrapping at 32 bits
  function automatic lane_pkg::elem_t alu_ref(input lane_pkg::alu_op_e op,
                                              input lane_pkg::elem_t a, b);
    case (op)
      lane_pkg::ADD: return a + b;
      lane_pkg::SUB: return a - b;
      lane_pkg::AND: return a & b;
      lane_pkg::OR:  return a | b;
      default:       return a ^ b;
    endcase
  endfunction

  task automatic check_value(input string name, input lane_pkg::elem_t exp, act);
    checks++;
    assert (act === exp) else begin
      $display("FAILED %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("ERROR timed out waiting for %s", what);
    errors++;
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors == errors_at_start) begin
      $display("%s: passed", name);
    end else begin
      failed_tests++;
      $display("%s: %0d errors", name, errors - errors_at_start);
    end
    errors_at_start = errors;
  endtask

  //////////////////////////////////////////////////
  // Port drivers
  //////////////////////////////////////////////////

  task automatic load_word(input lane_pkg::vaddr_t addr, input lane_pkg::elem_t data);
    int unsigned n;
    ldu_req   = '{we: 1'b1, addr: addr, wdata: data};
    ldu_valid = 1'b1;
    n = 0;
    @(negedge clk);
    while (!ldu_ready && n < timeout_cycles) begin
      @(negedge clk);
      n++;
    end
    if (ldu_ready) model[addr] = data;
    else report_timeout("load grant");
    @(posedge clk);
    #1;
    ldu_valid = 1'b0;
  endtask

  task automatic load_reg(input lane_pkg::vreg_t v);
    for (int e = 0; e < `LANE_ELEMS_PER_VREG; e++) begin
      load_word(word_addr(v, e), next_rand());
    end
  endtask

  // A nonzero hold keeps the consumer stalled and a second request pending
  task automatic store_read(input string name, input lane_pkg::vaddr_t addr, input int hold);
    int unsigned n;
    lane_pkg::elem_t first;
    stu_addr       = addr;
    stu_req_valid  = 1'b1;
    stu_data_ready = (hold == 0);
    n = 0;
    @(negedge clk);
    while (!stu_req_ready && n < timeout_cycles) begin
      @(negedge clk);
      n++;
    end
    if (!stu_req_ready) report_timeout("store request accept");
    @(posedge clk);
    #1;
    stu_addr      = addr + 1'b1;
    stu_req_valid = (hold != 0);
    n = 0;
    @(negedge clk);
    while (!stu_data_valid && n < timeout_cycles) begin
      @(negedge clk);
      n++;
    end
    if (!stu_data_valid) report_timeout("store data");
    first = stu_data;
    for (int i = 0; i < hold; i++) begin
      @(negedge clk);
      check_value({name, " stable"}, first, stu_data);
      check_value({name, " blocked"}, 1'b0, stu_req_ready);
    end
    if (hold != 0) begin
      @(posedge clk);
      #1;
      stu_req_valid  = 1'b0;
      stu_data_ready = 1'b1;
      @(negedge clk);
    end
    check_value({name, " valid"}, 1'b1, stu_data_valid);
    check_value(name, model[addr], stu_data);
    @(posedge clk);
    #1;
  endtask

  task automatic store_reg(input string name, input lane_pkg::vreg_t v);
    for (int e = 0; e < `LANE_ELEMS_PER_VREG; e++) begin
      store_read(name, word_addr(v, e), 0);
    end
  endtask

  task automatic start_cmd(input lane_pkg::alu_cmd_t c);
    int unsigned n;
    cmd       = c;
    cmd_valid = 1'b1;
    n = 0;
    @(negedge clk);
    while (!cmd_ready && n < timeout_cycles) begin
      @(negedge clk);
      n++;
    end
    if (!cmd_ready) report_timeout("command accept");
    @(posedge clk);
    #1;
    cmd_valid = 1'b0;
  endtask

  // Model takes the result once the instruction has completed
  task automatic finish_cmd(input lane_pkg::alu_cmd_t c);
    int unsigned n;
    n = 0;
    @(negedge clk);
    while (!alu_done && n < timeout_cycles) begin
      @(negedge clk);
      n++;
    end
    if (!alu_done) begin
      report_timeout("ALU done");
    end else begin
      for (int e = 0; e < `LANE_ELEMS_PER_VREG; e++) begin
        model[word_addr(c.vd, e)] = alu_ref(c.op, model[word_addr(c.vs1, e)],
                                            model[word_addr(c.vs2, e)]);
      end
    end
    @(posedge clk);
    #1;
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    lane_pkg::alu_cmd_t c;
    rng_state       = 32'h45f68416;
    errors          = 0;
    checks          = 0;
    tests           = 0;
    failed_tests    = 0;
    errors_at_start = 0;
    rst_n           = 1'b0;
    cmd             = '0;
    cmd_valid       = 1'b0;
    ldu_req         = '0;
    ldu_valid       = 1'b0;
    stu_addr        = '0;
    stu_req_valid   = 1'b0;
    stu_data_ready  = 1'b1;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;

    @(negedge clk);
    check_value("reset alu_done", 1'b0, alu_done);
    check_value("reset stu_data_valid", 1'b0, stu_data_valid);
    check_value("reset cmd_ready", 1'b1, cmd_ready);
    check_value("reset stu_req_ready", 1'b1, stu_req_ready);
    @(posedge clk);
    #1;
    end_test("reset");

    for (int a = 0; a < nr_words; a++) begin
      load_word(lane_pkg::vaddr_t'(a), next_rand());
    end
    for (int a = 0; a < nr_words; a++) begin
      store_read("load readback", lane_pkg::vaddr_t'(a), 0);
    end
    end_test("load_store");

    for (int i = 0; i < 5; i++) begin
      c = '{op: lane_pkg::alu_op_e'(i), vd: lane_pkg::vreg_t'(i + 2),
            vs1: lane_pkg::vreg_t'(i), vs2: lane_pkg::vreg_t'(i + 1)};
      load_reg(c.vs1);
      load_reg(c.vs2);
      start_cmd(c);
      finish_cmd(c);
      store_reg("alu result", c.vd);
    end
    end_test("alu_ops");

    store_read("back-pressure", lane_pkg::vaddr_t'(next_rand()), 6);
    store_read("back-pressure", lane_pkg::vaddr_t'(next_rand()), 3);
    end_test("back_pressure");

    // Loads to registers 0 and 1 while the ALU works on 5, 6 and 7
    c = '{op: lane_pkg::SUB, vd: 3'd7, vs1: 3'd5, vs2: 3'd6};
    start_cmd(c);
    load_reg(3'd0);
    load_reg(3'd1);
    finish_cmd(c);
    store_reg("contention alu", c.vd);
    store_reg("contention load", 3'd0);
    store_reg("contention load", 3'd1);
    end_test("contention");

    // Handshake assertion failures from the bound checker
    errors += vector_lane_inst.vector_lane_chk_inst.fail_count;

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests, failed_tests, checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src/lane_params.svh */
// Lane sizing macros shared by the package and the RTL

`ifndef LANE_PARAMS_SVH
`define LANE_PARAMS_SVH

//////////////////////////////////////////////////
// Datapath sizes
//////////////////////////////////////////////////

// Width of one vector element in bits
`define LANE_ELEM_W 32

// Architectural vector registers held in the VRF
`define LANE_NR_VREGS 8

// Elements per vector register, a whole register is always processed
`define LANE_ELEMS_PER_VREG 4

`endif

/* src/lane_pkg.sv */
// Lane package with element, address, command and VRF request types
`default_nettype none
`include "lane_params.svh"

package lane_pkg;

  //////////////////////////////////////////////////
  // Scalar types
  //////////////////////////////////////////////////

  typedef logic [`LANE_ELEM_W-1:0] elem_t;
  typedef logic [$clog2(`LANE_NR_VREGS)-1:0] vreg_t;
  typedef logic [$clog2(`LANE_ELEMS_PER_VREG)-1:0] elem_idx_t;

  // Register number in the upper bits, element index below
  typedef logic [$bits(vreg_t)+$bits(elem_idx_t)-1:0] vaddr_t;

  //////////////////////////////////////////////////
  // Enums
  //////////////////////////////////////////////////

  typedef enum logic [2:0] {
    ADD = 3'd0,
    SUB = 3'd1,
    AND = 3'd2,
    OR  = 3'd3,
    XOR = 3'd4
  } alu_op_e;

  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    READ_A = 2'd1,
    READ_B = 2'd2,
    WRITE  = 2'd3
  } alu_state_e;

  //////////////////////////////////////////////////
  // Structs
  //////////////////////////////////////////////////

  // One VRF access as presented to the arbiter
  typedef struct packed {
    logic   we;
    vaddr_t addr;
    elem_t  wdata;
  } vrf_req_t;

  // Arithmetic instruction, vd = vs1 op vs2
  typedef struct packed {
    alu_op_e op;
    vreg_t   vd;
    vreg_t   vs1;
    vreg_t   vs2;
  } alu_cmd_t;

endpackage

`default_nettype wire

/* src/store_reader.sv */
// Store reader, serves store-unit element reads and holds data under back-pressure
`timescale 1ns/1ps
`default_nettype none

module store_reader (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Store request side
  input  lane_pkg::vaddr_t   addr_i,
  input  logic               req_valid_i,
  output logic               req_ready_o,
  // VRF access through the arbiter
  output lane_pkg::vrf_req_t vrf_req_o,
  output logic               vrf_valid_o,
  input  logic               vrf_gnt_i,
  input  lane_pkg::elem_t    vrf_rdata_i,
  // Store data side
  output lane_pkg::elem_t    data_o,
  output logic               data_valid_o,
  input  logic               data_ready_i
);

  lane_pkg::vaddr_t addr_q;
  lane_pkg::elem_t  data_q;
  logic             pend_q, rd_q, hold_q;

  // One read in flight at a time
  assign req_ready_o = !(pend_q || rd_q || hold_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q <= 1'b0;
      rd_q   <= 1'b0;
      hold_q <= 1'b0;
    end else begin
      if (req_valid_i && req_ready_o) begin
        pend_q <= 1'b1;
      end else if (pend_q && vrf_gnt_i) begin
        pend_q <= 1'b0;
      end
      rd_q <= pend_q && vrf_gnt_i;
      if (rd_q && !data_ready_i) begin
        hold_q <= 1'b1;
      end else if (hold_q && data_ready_i) begin
        hold_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      addr_q <= addr_i;
    end
    if (rd_q) begin
      data_q <= vrf_rdata_i;
    end
  end

  assign vrf_req_o    = '{we: 1'b0, addr: addr_q, wdata: '0};
  assign vrf_valid_o  = pend_q;
  // Bypass in the arrival cycle, then the holding register
  assign data_o       = rd_q ? vrf_rdata_i : data_q;
  assign data_valid_o = rd_q || hold_q;

endmodule

`default_nettype wire

/* src/vector_alu_unit.sv */
// Vector ALU, runs one element-wise instruction through the shared VRF port
`timescale 1ns/1ps
`default_nettype none
`include "lane_params.svh"

module vector_alu_unit (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Command port
  input  lane_pkg::alu_cmd_t cmd_i,
  input  logic               cmd_valid_i,
  output logic               cmd_ready_o,
  // VRF access through the arbiter
  output lane_pkg::vrf_req_t vrf_req_o,
  output logic               vrf_valid_o,
  input  logic               vrf_gnt_i,
  input  lane_pkg::elem_t    vrf_rdata_i,
  // Completion pulse
  output logic               done_o
);

  localparam lane_pkg::elem_idx_t last_idx = lane_pkg::elem_idx_t'(`LANE_ELEMS_PER_VREG - 1);

  lane_pkg::alu_state_e state_q, state_d;
  lane_pkg::alu_cmd_t   cmd_q;
  lane_pkg::elem_idx_t  idx_q;
  logic                 rd_a_q, rd_b_q;
  logic                 done_q;
  lane_pkg::elem_t      op_a_q, op_b_q;
  lane_pkg::elem_t      op_b, result;
  logic                 cmd_fire;

  assign cmd_ready_o = (state_q == lane_pkg::IDLE);
  assign cmd_fire    = cmd_valid_i && cmd_ready_o;

  //////////////////////////////////////////////////
  // Element sequencing
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      lane_pkg::IDLE:   if (cmd_fire) state_d = lane_pkg::READ_A;
      lane_pkg::READ_A: if (vrf_gnt_i) state_d = lane_pkg::READ_B;
      lane_pkg::READ_B: if (vrf_gnt_i) state_d = lane_pkg::WRITE;
      lane_pkg::WRITE: begin
        if (vrf_gnt_i) begin
          state_d = (idx_q == last_idx) ? lane_pkg::IDLE : lane_pkg::READ_A;
        end
      end
      default: state_d = lane_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= lane_pkg::IDLE;
      idx_q   <= '0;
      rd_a_q  <= 1'b0;
      rd_b_q  <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      // Remember whose read lands on the shared data bus next cycle
      rd_a_q  <= vrf_gnt_i && (state_q == lane_pkg::READ_A);
      rd_b_q  <= vrf_gnt_i && (state_q == lane_pkg::READ_B);
      done_q  <= vrf_gnt_i && (state_q == lane_pkg::WRITE) && (idx_q == last_idx);
      if (cmd_fire) begin
        idx_q <= '0;
      end else if (vrf_gnt_i && (state_q == lane_pkg::WRITE)) begin
        idx_q <= idx_q + 1'b1;
      end
    end
  end

  // Command and operand holding registers
  always_ff @(posedge clk_i) begin
    if (cmd_fire) begin
      cmd_q <= cmd_i;
    end
    if (rd_a_q) begin
      op_a_q <= vrf_rdata_i;
    end
    if (rd_b_q) begin
      op_b_q <= vrf_rdata_i;
    end
  end

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////

  // Second operand straight from the VRF in its arrival cycle
  assign op_b = rd_b_q ? vrf_rdata_i : op_b_q;

  always_comb begin
    unique case (cmd_q.op)
      lane_pkg::ADD: result = op_a_q + op_b;
      lane_pkg::SUB: result = op_a_q - op_b;
      lane_pkg::AND: result = op_a_q & op_b;
      lane_pkg::OR:  result = op_a_q | op_b;
      lane_pkg::XOR: result = op_a_q ^ op_b;
      default:       result = '0;
    endcase
  end

  always_comb begin
    vrf_req_o = '0;
    unique case (state_q)
      lane_pkg::READ_A: vrf_req_o.addr = {cmd_q.vs1, idx_q};
      lane_pkg::READ_B: vrf_req_o.addr = {cmd_q.vs2, idx_q};
      lane_pkg::WRITE: begin
        vrf_req_o.we    = 1'b1;
        vrf_req_o.addr  = {cmd_q.vd, idx_q};
        vrf_req_o.wdata = result;
      end
      default: vrf_req_o = '0;
    endcase
  end

  assign vrf_valid_o = (state_q != lane_pkg::IDLE);
  assign done_o      = done_q;

endmodule

`default_nettype wire

/* src/vector_lane.sv */
// Vector lane top, ties the ALU, load and store ports to one shared VRF
`timescale 1ns/1ps
`default_nettype none

module vector_lane (
  input  logic               clk_i,
  input  logic               rst_ni,
  // ALU command port
  input  lane_pkg::alu_cmd_t cmd_i,
  input  logic               cmd_valid_i,
  output logic               cmd_ready_o,
  output logic               alu_done_o,
  // Load unit write port
  input  lane_pkg::vrf_req_t ldu_req_i,
  input  logic               ldu_valid_i,
  output logic               ldu_ready_o,
  // Store unit read port
  input  lane_pkg::vaddr_t   stu_addr_i,
  input  logic               stu_req_valid_i,
  output logic               stu_req_ready_o,
  output lane_pkg::elem_t    stu_data_o,
  output logic               stu_data_valid_o,
  input  logic               stu_data_ready_i
);

  lane_pkg::vrf_req_t alu_req, stu_req, mem_req;
  logic               alu_valid, alu_gnt;
  logic               stu_valid, stu_gnt;
  logic               mem_valid;
  lane_pkg::elem_t    vrf_rdata;

  //////////////////////////////////////////////////
  // Requesters
  //////////////////////////////////////////////////

  vector_alu_unit i_alu (
    .clk_i       (clk_i      ),
    .rst_ni      (rst_ni     ),
    .cmd_i       (cmd_i      ),
    .cmd_valid_i (cmd_valid_i),
    .cmd_ready_o (cmd_ready_o),
    .vrf_req_o   (alu_req    ),
    .vrf_valid_o (alu_valid  ),
    .vrf_gnt_i   (alu_gnt    ),
    .vrf_rdata_i (vrf_rdata  ),
    .done_o      (alu_done_o )
  );

  store_reader i_store_reader (
    .clk_i        (clk_i           ),
    .rst_ni       (rst_ni          ),
    .addr_i       (stu_addr_i      ),
    .req_valid_i  (stu_req_valid_i ),
    .req_ready_o  (stu_req_ready_o ),
    .vrf_req_o    (stu_req         ),
    .vrf_valid_o  (stu_valid       ),
    .vrf_gnt_i    (stu_gnt         ),
    .vrf_rdata_i  (vrf_rdata       ),
    .data_o       (stu_data_o      ),
    .data_valid_o (stu_data_valid_o),
    .data_ready_i (stu_data_ready_i)
  );

  //////////////////////////////////////////////////
  // Arbitration and storage
  //////////////////////////////////////////////////

  // Load port goes straight to the arbiter
  vrf_arbiter i_arbiter (
    .ldu_req_i   (ldu_req_i  ),
    .ldu_valid_i (ldu_valid_i),
    .ldu_gnt_o   (ldu_ready_o),
    .alu_req_i   (alu_req    ),
    .alu_valid_i (alu_valid  ),
    .alu_gnt_o   (alu_gnt    ),
    .stu_req_i   (stu_req    ),
    .stu_valid_i (stu_valid  ),
    .stu_gnt_o   (stu_gnt    ),
    .mem_req_o   (mem_req    ),
    .mem_valid_o (mem_valid  )
  );

  vector_regfile i_vrf (
    .clk_i       (clk_i    ),
    .rst_ni      (rst_ni   ),
    .req_i       (mem_req  ),
    .req_valid_i (mem_valid),
    .rdata_o     (vrf_rdata)
  );

endmodule

`default_nettype wire

/* src/vector_regfile.sv */
// Vector register file, single-port storage with one-cycle read latency
`timescale 1ns/1ps
`default_nettype none
`include "lane_params.svh"

module vector_regfile (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  lane_pkg::vrf_req_t req_i,
  input  logic               req_valid_i,
  output lane_pkg::elem_t    rdata_o
);

  localparam int unsigned nr_words = `LANE_NR_VREGS * `LANE_ELEMS_PER_VREG;

  lane_pkg::elem_t mem_q [nr_words];
  lane_pkg::elem_t rdata_q;

  // Storage array
  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_i.we) begin
      mem_q[req_i.addr] <= req_i.wdata;
    end
  end

  // Read data register, updated only by a granted read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (req_valid_i && !req_i.we) begin
      rdata_q <= mem_q[req_i.addr];
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

/* src/vrf_arbiter.sv */
// Fixed-priority VRF arbiter for the load, ALU and store requesters
`timescale 1ns/1ps
`default_nettype none

module vrf_arbiter (
  // Load unit, highest priority
  input  lane_pkg::vrf_req_t ldu_req_i,
  input  logic               ldu_valid_i,
  output logic               ldu_gnt_o,
  // Vector ALU
  input  lane_pkg::vrf_req_t alu_req_i,
  input  logic               alu_valid_i,
  output logic               alu_gnt_o,
  // Store reader, lowest priority
  input  lane_pkg::vrf_req_t stu_req_i,
  input  logic               stu_valid_i,
  output logic               stu_gnt_o,
  // Towards the VRF
  output lane_pkg::vrf_req_t mem_req_o,
  output logic               mem_valid_o
);

  //////////////////////////////////////////////////
  // Grant logic
  //////////////////////////////////////////////////

  // At most one grant, and only alongside its own request
  always_comb begin
    ldu_gnt_o = ldu_valid_i;
    alu_gnt_o = alu_valid_i && !ldu_valid_i;
    stu_gnt_o = stu_valid_i && !ldu_valid_i && !alu_valid_i;
  end

  //////////////////////////////////////////////////
  // Request mux
  //////////////////////////////////////////////////

  always_comb begin
    mem_req_o = '0;
    if (ldu_gnt_o) begin
      mem_req_o    = ldu_req_i;
      // Load port always writes
      mem_req_o.we = 1'b1;
    end else if (alu_gnt_o) begin
      mem_req_o = alu_req_i;
    end else if (stu_gnt_o) begin
      mem_req_o    = stu_req_i;
      // Store port is read only
      mem_req_o.we = 1'b0;
    end
  end

  assign mem_valid_o = ldu_gnt_o || alu_gnt_o || stu_gnt_o;

endmodule

`default_nettype wire

/* vector_lane.f */
+incdir+src
src/lane_pkg.sv
src/vector_regfile.sv
src/vrf_arbiter.sv
src/vector_alu_unit.sv
src/store_reader.sv
src/vector_lane.sv
dv/vector_lane_chk.sv
dv/vector_lane_tb.sv
